// File: verilog/order_book_params.svh
/* book sizes and field widths shared by every block of the order book
   depth and stock count must be powers of two for the slot and stock indexes */
`ifndef ORDER_BOOK_PARAMS_SVH
`define ORDER_BOOK_PARAMS_SVH

`define OB_NUM_STOCKS 4
`define OB_BOOK_DEPTH 8

// field widths of one order
`define OB_PRICE_W 32
`define OB_QTY_W   16
`define OB_ID_W    32

`endif

// File: verilog/order_book_pkg.sv
/* types shared by the order book blocks, sized from the params header */
`include "order_book_params.svh"

package order_book_pkg;

    typedef logic [`OB_PRICE_W-1:0] price_t;
    typedef logic [`OB_QTY_W-1:0] qty_t;
    typedef logic [`OB_ID_W-1:0] order_id_t;
    typedef logic [$clog2(`OB_NUM_STOCKS)-1:0] stock_id_t;
    typedef logic [$clog2(`OB_BOOK_DEPTH)-1:0] slot_t;
    // one extra bit so a full side can be counted
    typedef logic [$clog2(`OB_BOOK_DEPTH+1)-1:0] count_t;

    typedef enum logic [1:0] {
        CMD_ADD      = 2'd0,
        CMD_CANCEL   = 2'd1,
        CMD_EXECUTE  = 2'd2,
        CMD_RESERVED = 2'd3
    } cmd_t;

    typedef enum logic [2:0] {
        ST_IDLE, ST_ADD, ST_SEARCH, ST_FILL, ST_SHIFT, ST_SCAN, ST_FINISH
    } ctrl_state_t;

endpackage

// File: verilog/order_book_ctrl.sv
/* command fields must stay stable from i_data_valid until o_data_valid;
   the reserved command code is never accepted */
`timescale 1ns/1ps

module order_book_ctrl (
    input  logic                 i_clk,
    input  logic                 i_reset_n,
    input  logic                 i_data_valid,
    input  order_book_pkg::cmd_t i_order_type,
    input  logic                 i_trading_logic_ready,
    input  logic                 i_match,
    input  logic                 i_fill_closes,
    input  logic                 i_last_slot,
    output logic                 o_add,
    output logic                 o_fill,
    output logic                 o_shift,
    output logic                 o_counter_clear,
    output logic                 o_counter_load,
    output logic                 o_counter_step,
    output logic                 o_scan_step,
    output logic                 o_scan_done,
    output logic                 o_curr_price_add,
    output logic                 o_curr_price_clear,
    output logic                 o_book_is_busy,
    output logic                 o_data_valid
);
    import order_book_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        is_search_cmd;

    assign is_search_cmd = (i_order_type == CMD_CANCEL) || (i_order_type == CMD_EXECUTE);

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next         = state;
        o_add              = 1'b0;
        o_fill             = 1'b0;
        o_shift            = 1'b0;
        o_counter_clear    = 1'b0;
        o_counter_load     = 1'b0;
        o_counter_step     = 1'b0;
        o_scan_step        = 1'b0;
        o_scan_done        = 1'b0;
        o_curr_price_add   = 1'b0;
        o_curr_price_clear = 1'b0;
        case (state)
            ST_IDLE: begin
                if (i_data_valid && (i_order_type == CMD_ADD)) begin
                    state_next = ST_ADD;
                end else if (i_data_valid && is_search_cmd) begin
                    // search starts at slot 0
                    o_counter_clear    = 1'b1;
                    o_curr_price_clear = 1'b1;
                    state_next         = ST_SEARCH;
                end
            end
            ST_ADD: begin
                o_add            = 1'b1;
                o_curr_price_add = 1'b1;
                o_counter_clear  = 1'b1;
                state_next       = ST_SCAN;
            end
            ST_SEARCH: begin
                if (i_match && (i_order_type == CMD_EXECUTE)) begin
                    state_next = ST_FILL;
                end else if (i_match) begin
                    // park the counter on the matched slot
                    o_counter_load = 1'b1;
                    state_next     = ST_SHIFT;
                end else if (i_last_slot) begin
                    o_counter_clear = 1'b1;
                    state_next      = ST_SCAN;
                end else begin
                    o_counter_step = 1'b1;
                end
            end
            ST_FILL: begin
                if (i_fill_closes) begin
                    // order fully taken, remove it instead
                    o_counter_load = 1'b1;
                    state_next     = ST_SHIFT;
                end else begin
                    o_fill          = 1'b1;
                    o_counter_clear = 1'b1;
                    state_next      = ST_SCAN;
                end
            end
            ST_SHIFT: begin
                o_shift = 1'b1;
                if (i_last_slot) begin
                    o_counter_clear = 1'b1;
                    state_next      = ST_SCAN;
                end else begin
                    o_counter_step = 1'b1;
                end
            end
            ST_SCAN: begin
                o_scan_step = 1'b1;
                if (i_last_slot) begin
                    o_scan_done = 1'b1;
                    state_next  = ST_FINISH;
                end else begin
                    o_counter_step = 1'b1;
                end
            end
            ST_FINISH: begin
                if (i_trading_logic_ready) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    assign o_book_is_busy = (state != ST_IDLE) && (state != ST_FINISH);
    assign o_data_valid   = (state == ST_FINISH);

    a_valid_not_busy: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !(o_data_valid && o_book_is_busy));

endmodule

// File: verilog/slot_scan_counter.sv
/* clear wins over load, load wins over step; stepping stops at the last slot */
`timescale 1ns/1ps
`include "order_book_params.svh"

module slot_scan_counter (
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  logic                  i_clear,
    input  logic                  i_load,
    input  order_book_pkg::slot_t i_load_value,
    input  logic                  i_step,
    output order_book_pkg::slot_t o_index,
    output logic                  o_last
);
    import order_book_pkg::*;

    always_ff @(posedge i_clk) begin
        if (!i_reset_n || i_clear) begin
            o_index <= '0;
        end else if (i_load) begin
            o_index <= i_load_value;
        end else if (i_step) begin
            o_index <= o_index + slot_t'(1);
        end
    end

    assign o_last = (o_index == slot_t'(`OB_BOOK_DEPTH - 1));

    a_no_wrap: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_step && !i_clear && !i_load |-> !o_last);

endmodule

// File: verilog/side_book.sv
/* one side of the book for all stocks; live orders sit packed in slots 0..count-1
   order ids are assumed unique within a stock side */
`timescale 1ns/1ps
`include "order_book_params.svh"

module side_book (
    input  logic                      i_clk,
    input  logic                      i_reset_n,
    input  order_book_pkg::stock_id_t i_stock_id,
    input  order_book_pkg::slot_t     i_index,
    input  logic                      i_add,
    input  logic                      i_fill,
    input  logic                      i_shift,
    input  order_book_pkg::qty_t      i_quantity,
    input  order_book_pkg::price_t    i_price,
    input  order_book_pkg::order_id_t i_order_id,
    output logic                      o_match,
    output logic                      o_fill_closes,
    output logic                      o_slot_valid,
    output order_book_pkg::price_t    o_slot_price
);
    import order_book_pkg::*;

    localparam int DEPTH = `OB_BOOK_DEPTH;

    qty_t      qty_mem   [`OB_NUM_STOCKS][DEPTH];
    price_t    price_mem [`OB_NUM_STOCKS][DEPTH];
    order_id_t id_mem    [`OB_NUM_STOCKS][DEPTH];
    count_t    count     [`OB_NUM_STOCKS];

    count_t cur_count;
    logic   is_full;
    logic   at_last;
    slot_t  next_index;

    assign cur_count  = count[i_stock_id];
    assign is_full    = (cur_count == count_t'(DEPTH));
    assign at_last    = (i_index == slot_t'(DEPTH - 1));
    assign next_index = i_index + slot_t'(1);

    // slot lookups at the counter index
    assign o_slot_valid  = (count_t'(i_index) < cur_count);
    assign o_slot_price  = price_mem[i_stock_id][i_index];
    assign o_match       = o_slot_valid && (id_mem[i_stock_id][i_index] == i_order_id);
    assign o_fill_closes = (qty_mem[i_stock_id][i_index] <= i_quantity);

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            for (int s = 0; s < `OB_NUM_STOCKS; s++) begin
                count[s] <= '0;
            end
        end else if (i_add && !is_full) begin
            count[i_stock_id] <= cur_count + count_t'(1);
        end else if (i_shift && at_last) begin
            count[i_stock_id] <= cur_count - count_t'(1);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_add && !is_full) begin
            // append behind the newest order, drop when full
            qty_mem[i_stock_id][slot_t'(cur_count)]   <= i_quantity;
            price_mem[i_stock_id][slot_t'(cur_count)] <= i_price;
            id_mem[i_stock_id][slot_t'(cur_count)]    <= i_order_id;
        end else if (i_fill) begin
            qty_mem[i_stock_id][i_index] <= qty_mem[i_stock_id][i_index] - i_quantity;
        end else if (i_shift && at_last) begin
            qty_mem[i_stock_id][i_index]   <= '0;
            price_mem[i_stock_id][i_index] <= '0;
            id_mem[i_stock_id][i_index]    <= '0;
        end else if (i_shift) begin
            // pull the later entry down one slot
            qty_mem[i_stock_id][i_index]   <= qty_mem[i_stock_id][next_index];
            price_mem[i_stock_id][i_index] <= price_mem[i_stock_id][next_index];
            id_mem[i_stock_id][i_index]    <= id_mem[i_stock_id][next_index];
        end
    end

    generate
        for (genvar s = 0; s < `OB_NUM_STOCKS; s++) begin : g_count_chk
            a_count_bound: assert property (@(posedge i_clk) disable iff (!i_reset_n)
                count[s] <= count_t'(DEPTH));
        end
    endgenerate

endmodule

// File: verilog/best_price_tracker.sv
/* IS_BID=1 keeps the highest live price, 0 the lowest; an empty side stores 0
   the stock id must not change during a scan */
`timescale 1ns/1ps
`include "order_book_params.svh"

module best_price_tracker #(
    parameter bit IS_BID = 1'b1
) (
    input  logic                      i_clk,
    input  logic                      i_reset_n,
    input  order_book_pkg::stock_id_t i_stock_id,
    input  logic                      i_scan_step,
    input  logic                      i_scan_done,
    input  logic                      i_slot_valid,
    input  order_book_pkg::price_t    i_slot_price,
    output order_book_pkg::price_t    o_best
);
    import order_book_pkg::*;

    price_t best_q [`OB_NUM_STOCKS];
    price_t acc_price;
    logic   acc_found;
    price_t acc_price_next;
    logic   acc_found_next;
    logic   better;
    price_t scan_result;

    assign better = IS_BID ? (i_slot_price > acc_price) : (i_slot_price < acc_price);

    always_comb begin
        acc_price_next = acc_price;
        acc_found_next = acc_found;
        if (i_scan_step && i_slot_valid && (!acc_found || better)) begin
            acc_price_next = i_slot_price;
            acc_found_next = 1'b1;
        end
    end

    // last slot is folded in on the done cycle
    assign scan_result = acc_found_next ? acc_price_next : '0;

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            acc_found <= 1'b0;
            for (int s = 0; s < `OB_NUM_STOCKS; s++) begin
                best_q[s] <= '0;
            end
        end else if (i_scan_done) begin
            best_q[i_stock_id] <= scan_result;
            acc_found          <= 1'b0;
        end else begin
            acc_price <= acc_price_next;
            acc_found <= acc_found_next;
        end
    end

    // forward the value being stored so the top register sees it on the same edge
    assign o_best = i_scan_done ? scan_result : best_q[i_stock_id];

endmodule

// File: verilog/order_book.sv
/* i_trade_type 1 selects the bid side, 0 the ask side; inputs held stable per command
   best prices follow i_stock_id with one cycle of delay */
`timescale 1ns/1ps

module order_book (
    input  logic                      i_clk,
    input  logic                      i_reset_n,
    input  logic                      i_data_valid,
    input  logic                      i_trade_type,
    input  order_book_pkg::stock_id_t i_stock_id,
    input  order_book_pkg::cmd_t      i_order_type,
    input  order_book_pkg::qty_t      i_quantity,
    input  order_book_pkg::price_t    i_price,
    input  order_book_pkg::order_id_t i_order_id,
    input  logic                      i_trading_logic_ready,
    output order_book_pkg::price_t    o_curr_price,
    output order_book_pkg::price_t    o_best_bid,
    output order_book_pkg::price_t    o_best_ask,
    output logic                      o_book_is_busy,
    output logic                      o_data_valid
);
    import order_book_pkg::*;

    logic   ctrl_add, ctrl_fill, ctrl_shift;
    logic   cnt_clear, cnt_load, cnt_step;
    logic   scan_step, scan_done;
    logic   price_add, price_clear;
    slot_t  slot_index;
    logic   last_slot;
    logic   bid_match, ask_match, sel_match;
    logic   bid_fill_closes, ask_fill_closes, sel_fill_closes;
    logic   bid_slot_valid, ask_slot_valid;
    price_t bid_slot_price, ask_slot_price;
    price_t bid_best, ask_best;

    assign sel_match       = i_trade_type ? bid_match : ask_match;
    assign sel_fill_closes = i_trade_type ? bid_fill_closes : ask_fill_closes;

    order_book_ctrl u_ctrl (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_data_valid(i_data_valid),
        .i_order_type(i_order_type), .i_trading_logic_ready(i_trading_logic_ready),
        .i_match(sel_match), .i_fill_closes(sel_fill_closes), .i_last_slot(last_slot),
        .o_add(ctrl_add), .o_fill(ctrl_fill), .o_shift(ctrl_shift),
        .o_counter_clear(cnt_clear), .o_counter_load(cnt_load), .o_counter_step(cnt_step),
        .o_scan_step(scan_step), .o_scan_done(scan_done),
        .o_curr_price_add(price_add), .o_curr_price_clear(price_clear),
        .o_book_is_busy(o_book_is_busy), .o_data_valid(o_data_valid)
    );

    slot_scan_counter u_counter (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_clear(cnt_clear), .i_load(cnt_load),
        .i_load_value(slot_index), .i_step(cnt_step), .o_index(slot_index), .o_last(last_slot)
    );

    side_book u_bid_book (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_stock_id(i_stock_id), .i_index(slot_index),
        .i_add(ctrl_add & i_trade_type), .i_fill(ctrl_fill & i_trade_type),
        .i_shift(ctrl_shift & i_trade_type), .i_quantity(i_quantity), .i_price(i_price),
        .i_order_id(i_order_id), .o_match(bid_match), .o_fill_closes(bid_fill_closes),
        .o_slot_valid(bid_slot_valid), .o_slot_price(bid_slot_price)
    );

    side_book u_ask_book (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_stock_id(i_stock_id), .i_index(slot_index),
        .i_add(ctrl_add & ~i_trade_type), .i_fill(ctrl_fill & ~i_trade_type),
        .i_shift(ctrl_shift & ~i_trade_type), .i_quantity(i_quantity), .i_price(i_price),
        .i_order_id(i_order_id), .o_match(ask_match), .o_fill_closes(ask_fill_closes),
        .o_slot_valid(ask_slot_valid), .o_slot_price(ask_slot_price)
    );

    best_price_tracker #(.IS_BID(1'b1)) u_bid_tracker (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_stock_id(i_stock_id),
        .i_scan_step(scan_step & i_trade_type), .i_scan_done(scan_done & i_trade_type),
        .i_slot_valid(bid_slot_valid), .i_slot_price(bid_slot_price), .o_best(bid_best)
    );

    best_price_tracker #(.IS_BID(1'b0)) u_ask_tracker (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_stock_id(i_stock_id),
        .i_scan_step(scan_step & ~i_trade_type), .i_scan_done(scan_done & ~i_trade_type),
        .i_slot_valid(ask_slot_valid), .i_slot_price(ask_slot_price), .o_best(ask_best)
    );

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            o_best_bid   <= '0;
            o_best_ask   <= '0;
            o_curr_price <= '0;
        end else begin
            o_best_bid <= bid_best;
            o_best_ask <= ask_best;
            // last add price, zeroed by cancel and execute
            if (price_add) begin
                o_curr_price <= i_price;
            end else if (price_clear) begin
                o_curr_price <= '0;
            end
        end
    end

endmodule

// File: verif/order_book_tb.sv
/* self-checking testbench; order ids are unique and start at 1, prices are never 0
   results are checked by concurrent assertions while o_data_valid is high */
`timescale 1ns/1ps
`include "order_book_params.svh"

module order_book_tb;
    import order_book_pkg::*;

    localparam int CLK_PERIOD      = 8;
    localparam int DEPTH           = `OB_BOOK_DEPTH;
    localparam int MAX_CMDS        = 100;
    localparam int MAX_STALL       = 8;
    localparam int WATCHDOG_CYCLES = 20 + MAX_CMDS * (4 * DEPTH + 4 + MAX_STALL);

    logic      i_clk = 1'b0;
    logic      i_reset_n, i_data_valid, i_trade_type, i_trading_logic_ready;
    stock_id_t i_stock_id;
    cmd_t      i_order_type;
    qty_t      i_quantity;
    price_t    i_price;
    order_id_t i_order_id;
    price_t    o_curr_price, o_best_bid, o_best_ask;
    logic      o_book_is_busy, o_data_valid;

    // reference book, side index 1 is bids
    price_t    ref_price [2][`OB_NUM_STOCKS][DEPTH];
    qty_t      ref_qty   [2][`OB_NUM_STOCKS][DEPTH];
    order_id_t ref_id    [2][`OB_NUM_STOCKS][DEPTH];
    int        ref_count [2][`OB_NUM_STOCKS] = '{default: 0};
    price_t    exp_bid = '0;
    price_t    exp_ask = '0;
    price_t    exp_curr = '0;
    logic [15:0] lfsr = 16'd3092;
    order_id_t next_id = 1;
    int        issued = 0;
    int        results_seen = 0;
    logic      reset_check = 1'b0;
    string     test_name = "reset";

    order_book u_order_book (.*);

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    always @(posedge i_clk) begin
        if (i_reset_n && o_data_valid && i_trading_logic_ready) begin
            results_seen <= results_seen + 1;
        end
    end

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
        $display("TEST FAIL");
        $fatal(1, "stopping at first error");
    endtask

    // taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic int unsigned take_bits(input int n);
        int unsigned value;
        value = 0;
        for (int b = 0; b < n; b++) begin
            lfsr  = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            value = (value << 1) | lfsr[0];
        end
        return value;
    endfunction

    // first slot with the best price, -1 when the side is empty
    function automatic int slot_of_best(input int side, input int stock);
        int best;
        best = -1;
        for (int k = 0; k < ref_count[side][stock]; k++) begin
            if (best < 0) begin
                best = k;
            end else if (side == 1 ? ref_price[side][stock][k] > ref_price[side][stock][best]
                                   : ref_price[side][stock][k] < ref_price[side][stock][best]) begin
                best = k;
            end
        end
        return best;
    endfunction

    function automatic price_t best_price(input int side, input int stock);
        int slot;
        slot = slot_of_best(side, stock);
        return (slot < 0) ? price_t'(0) : ref_price[side][stock][slot];
    endfunction

    task automatic update_model(input cmd_t cmd, input int side, input int stock,
                                input qty_t qty, input price_t price, input order_id_t id);
        int n;
        int hit;
        n   = ref_count[side][stock];
        hit = -1;
        for (int k = 0; k < n; k++) begin
            if (ref_id[side][stock][k] == id) begin
                hit = k;
            end
        end
        exp_curr = (cmd == CMD_ADD) ? price : price_t'(0);
        if (cmd == CMD_ADD && n < DEPTH) begin
            ref_price[side][stock][n] = price;
            ref_qty[side][stock][n]   = qty;
            ref_id[side][stock][n]    = id;
            ref_count[side][stock]    = n + 1;
        end else if (cmd == CMD_EXECUTE && hit >= 0 && ref_qty[side][stock][hit] > qty) begin
            ref_qty[side][stock][hit] -= qty;
        end else if (cmd != CMD_ADD && hit >= 0) begin
            // later orders move down one slot
            for (int k = hit; k < n - 1; k++) begin
                ref_price[side][stock][k] = ref_price[side][stock][k + 1];
                ref_qty[side][stock][k]   = ref_qty[side][stock][k + 1];
                ref_id[side][stock][k]    = ref_id[side][stock][k + 1];
            end
            ref_count[side][stock] = n - 1;
        end
        exp_bid = best_price(1, stock);
        exp_ask = best_price(0, stock);
    endtask

    // starts and ends on a falling edge with the DUT idle
    task automatic run_command(input cmd_t cmd, input int side, input int stock,
                               input qty_t qty, input price_t price, input order_id_t id,
                               input int stall);
        update_model(cmd, side, stock, qty, price, id);
        i_order_type          = cmd;
        i_trade_type          = side[0];
        i_stock_id            = stock_id_t'(stock);
        i_quantity            = qty;
        i_price               = price;
        i_order_id            = id;
        i_trading_logic_ready = (stall == 0);
        i_data_valid          = 1'b1;
        issued++;
        @(negedge i_clk);
        i_data_valid = 1'b0;
        while (!o_data_valid) begin
            @(negedge i_clk);
        end
        repeat (stall) @(negedge i_clk);
        i_trading_logic_ready = 1'b1;
        @(negedge i_clk);
    endtask

    task automatic add_order(input int side, input int stock, input price_t price);
        run_command(CMD_ADD, side, stock, qty_t'(take_bits(8) + 2), price, next_id, 0);
        next_id++;
    endtask

    task automatic cancel_best(input int side, input int stock, input int stall);
        int slot;
        slot = slot_of_best(side, stock);
        run_command(CMD_CANCEL, side, stock, '0, '0,
                    (slot < 0) ? 32'hDEAD_0000 : ref_id[side][stock][slot], stall);
    endtask

    a_reset_flags: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        reset_check |-> !o_data_valid && !o_book_is_busy)
        else report_value("reset valid and busy", 0, $sampled({o_data_valid, o_book_is_busy}));
    a_reset_best: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        reset_check |-> (o_best_bid | o_best_ask) == '0)
        else report_value("reset best prices", 0, $sampled(o_best_bid | o_best_ask));
    a_busy_accept: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_data_valid |=> o_book_is_busy)
        else report_value({test_name, " busy after accept"}, 1, $sampled(o_book_is_busy));
    a_busy_held: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        o_book_is_busy |=> o_book_is_busy || o_data_valid)
        else report_value({test_name, " busy until result"}, 1, $sampled(o_book_is_busy));
    a_best_bid: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        o_data_valid |-> o_best_bid == exp_bid)
        else report_value({test_name, " best bid"}, exp_bid, $sampled(o_best_bid));
    a_best_ask: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        o_data_valid |-> o_best_ask == exp_ask)
        else report_value({test_name, " best ask"}, exp_ask, $sampled(o_best_ask));
    a_curr_price: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        o_data_valid |-> o_curr_price == exp_curr)
        else report_value({test_name, " current price"}, exp_curr, $sampled(o_curr_price));
    a_exclusive: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !(o_data_valid && o_book_is_busy))
        else report_value({test_name, " valid with busy"}, 0, 1);
    a_stall_valid: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        o_data_valid && !i_trading_logic_ready |=> o_data_valid)
        else report_value({test_name, " valid held"}, 1, $sampled(o_data_valid));
    a_stall_idle: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        o_data_valid && !i_trading_logic_ready |=> !o_book_is_busy)
        else report_value({test_name, " busy during stall"}, 0, $sampled(o_book_is_busy));

    initial begin
        int        side;
        int        stock;
        int        slot;
        order_id_t id;
        i_reset_n             = 1'b0;
        i_data_valid          = 1'b0;
        i_trade_type          = 1'b0;
        i_trading_logic_ready = 1'b1;
        i_stock_id            = '0;
        i_order_type          = CMD_ADD;
        i_quantity            = '0;
        i_price               = '0;
        i_order_id            = '0;
        repeat (10) @(posedge i_clk);
        @(negedge i_clk);
        i_reset_n   = 1'b1;
        reset_check = 1'b1;
        repeat (3) @(negedge i_clk);
        reset_check = 1'b0;

        test_name = "adds";
        repeat (24) begin
            side  = take_bits(1);
            stock = take_bits(2);
            add_order(side, stock, price_t'(take_bits(12) + 100));
        end

        test_name = "cancel";
        repeat (8) begin
            side  = take_bits(1);
            stock = take_bits(2);
            cancel_best(side, stock, 0);
        end
        run_command(CMD_CANCEL, 1, 0, '0, '0, 32'hDEAD_0001, 0);
        run_command(CMD_CANCEL, 0, 1, '0, '0, 32'hDEAD_0002, 0);
        // drain one side down to empty, then once more
        while (ref_count[1][2] > 0) begin
            cancel_best(1, 2, 0);
        end
        cancel_best(1, 2, 0);

        test_name = "execute";
        for (int n = 0; n < 4; n++) begin
            side  = n % 2;
            stock = n;
            if (ref_count[side][stock] == 0) begin
                add_order(side, stock, price_t'(take_bits(12) + 100));
            end
            slot = slot_of_best(side, stock);
            id   = ref_id[side][stock][slot];
            run_command(CMD_EXECUTE, side, stock, ref_qty[side][stock][slot] - 1, '0, id, 0);
            run_command(CMD_EXECUTE, side, stock, qty_t'(1 + take_bits(2)), '0, id, 0);
        end

        test_name = "full side";
        while (ref_count[1][1] < DEPTH) begin
            add_order(1, 1, price_t'(take_bits(12) + 100));
        end
        add_order(1, 1, 32'h00FF_FFFF);
        while (ref_count[0][3] < DEPTH) begin
            add_order(0, 3, price_t'(take_bits(12) + 100));
        end
        add_order(0, 3, 32'd1);

        test_name = "backpressure";
        for (int n = 0; n < 4; n++) begin
            stock = take_bits(2);
            run_command(CMD_ADD, n % 2, stock, 16'd5, price_t'(take_bits(12) + 100),
                        next_id, 2 + n);
            next_id++;
            cancel_best(n % 2, stock, 3);
        end

        @(negedge i_clk);
        if (results_seen != issued) begin
            $display("%0d results seen for %0d commands issued", results_seen, issued);
            $display("TEST FAIL");
            $fatal(1, "result count mismatch");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before all commands completed");
        $display("TEST FAIL");
        $fatal(1, "timeout");
    end

endmodule

// File: order_book.f
+incdir+verilog
verilog/order_book_pkg.sv
verilog/order_book_ctrl.sv
verilog/slot_scan_counter.sv
verilog/side_book.sv
verilog/best_price_tracker.sv
verilog/order_book.sv
verif/order_book_tb.sv
